// ==== verilog/uart_bus_pkg.sv ====
/*
 * register bus types for the serial port
 * one-cycle request strobe, registered read response,
 * offsets of the four word registers and status bit positions
 */
package uart_bus_pkg;

    typedef struct packed {
        logic        sel;       // one-cycle request strobe
        logic        write;
        logic [15:0] addr;
        logic [15:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic        valid;     // one cycle, the cycle after a read hit
        logic [15:0] rdata;
    } bus_rsp_t;

    // word offsets from the base address
    typedef enum logic [1:0] {
        reg_ctrl    = 2'd0,     // write bit 0 starts tx, read gives status
        reg_tx_data = 2'd1,
        reg_irq_en  = 2'd2,
        reg_rx_data = 2'd3      // read only
    } reg_offset_e;

    // status word, read at reg_ctrl
    localparam int stat_tx_busy    = 0;
    localparam int stat_rx_valid   = 1;
    localparam int stat_rx_overrun = 2;

endpackage

// ==== verilog/uart_line_pkg.sv ====
/*
 * serial line definitions
 * 8N1 frame size, tx and rx engine states,
 * and the command and event structs between registers and engines
 */
package uart_line_pkg;

    localparam int frame_bits = 8;     // data bits per frame, no parity

    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } tx_state_e;

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_e;

    // registers to transmitter
    typedef struct packed {
        logic                  start;  // one-cycle strobe
        logic [frame_bits-1:0] data;
    } tx_cmd_t;

    // receiver to registers
    typedef struct packed {
        logic                  done;   // one-cycle strobe, frame accepted
        logic [frame_bits-1:0] data;
    } rx_evt_t;

endpackage

// ==== verilog/baud_tick_gen.sv ====
`timescale 1ns/10ps
/*
 * bit-rate tick generator
 * free-running divider, one-cycle tick every clks_per_bit clocks
 */
module baud_tick_gen #(
    parameter int clks_per_bit = 16
) (
    input  logic clk,
    input  logic reset,
    output logic tick
);

    localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(clks_per_bit - 1);

    logic [cnt_w-1:0] count;

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            count <= '0;
            tick  <= 1'b0;
        end
        else
        begin
            tick  <= (count == cnt_last);   // registered, first tick clks_per_bit after reset
            if (count == cnt_last)
                count <= '0;
            else
                count <= count + 1'b1;
        end
    end

endmodule

// ==== verilog/uart_tx.sv ====
`timescale 1ns/10ps
/*
 * transmit engine
 * latches a byte on the start command and shifts it out as an
 * 8N1 frame, one bit per tick, LSB first
 */
module uart_tx (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   tick,
    input  uart_line_pkg::tx_cmd_t tx_cmd,
    output logic                   tx,
    output logic                   tx_busy
);
    import uart_line_pkg::*;

    localparam int bit_w = $clog2(frame_bits);
    localparam logic [bit_w-1:0] bit_last = bit_w'(frame_bits - 1);

    tx_state_e             state;
    logic [frame_bits-1:0] shift;
    logic [bit_w-1:0]      bit_cnt;
    logic                  accept;

    // new command only when nothing is pending or on the line
    assign accept = (state == tx_idle) && !tx_busy && tx_cmd.start;

    always_ff @(posedge clk)
    begin
        if (accept)
            shift <= tx_cmd.data;
        else if (tick && (state == tx_start || state == tx_data))
            shift <= shift >> 1;    // next data bit into shift[0]
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state   <= tx_idle;
            tx      <= 1'b1;
            tx_busy <= 1'b0;
            bit_cnt <= '0;
        end
        else
        begin
            case (state)
                tx_idle:
                begin
                    if (tx_busy && tick)
                    begin
                        tx    <= 1'b0;      // start bit
                        state <= tx_start;
                    end
                    else if (accept)
                        tx_busy <= 1'b1;    // pending until the next tick
                end
                tx_start:
                begin
                    if (tick)
                    begin
                        tx      <= shift[0];
                        bit_cnt <= '0;
                        state   <= tx_data;
                    end
                end
                tx_data:
                begin
                    if (tick)
                    begin
                        if (bit_cnt == bit_last)
                        begin
                            tx    <= 1'b1;  // stop bit
                            state <= tx_stop;
                        end
                        else
                        begin
                            tx      <= shift[0];
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                tx_stop:
                begin
                    if (tick)
                    begin
                        tx_busy <= 1'b0;
                        state   <= tx_idle;
                    end
                end
                default: state <= tx_idle;
            endcase
        end
    end

endmodule

// ==== verilog/uart_rx.sv ====
`timescale 1ns/10ps
/*
 * receive engine
 * synchronizes the line, times itself from the start-bit falling edge
 * and samples each bit in its middle; a bad start or stop bit drops the frame
 */
module uart_rx #(
    parameter int clks_per_bit = 16
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   rx,
    output uart_line_pkg::rx_evt_t rx_evt
);
    import uart_line_pkg::*;

    localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
    localparam logic [cnt_w-1:0] half_last = cnt_w'(clks_per_bit / 2 - 1);
    localparam logic [cnt_w-1:0] bit_last  = cnt_w'(clks_per_bit - 1);
    localparam int bit_w = $clog2(frame_bits);
    localparam logic [bit_w-1:0] data_last = bit_w'(frame_bits - 1);

    logic                  rx_meta;
    logic                  rx_sync;
    rx_state_e             state;
    logic [cnt_w-1:0]      clk_cnt;
    logic [bit_w-1:0]      bit_cnt;
    logic [frame_bits-1:0] shift;
    logic                  done;
    logic                  sample;

    // sample point of a data bit
    assign sample = (state == rx_data) && (clk_cnt == bit_last);

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            rx_meta <= 1'b1;    // idle line level
            rx_sync <= 1'b1;
        end
        else
        begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk)
    begin
        if (sample)
            shift <= {rx_sync, shift[frame_bits-1:1]};  // lsb arrives first
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state   <= rx_idle;
            clk_cnt <= '0;
            bit_cnt <= '0;
            done    <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                rx_idle:
                begin
                    clk_cnt <= '0;
                    if (!rx_sync)
                        state <= rx_start;  // falling edge of start bit
                end
                rx_start:
                begin
                    if (clk_cnt == half_last)
                    begin
                        clk_cnt <= '0;
                        bit_cnt <= '0;
                        state   <= rx_sync ? rx_idle : rx_data;  // glitch, not a start
                    end
                    else
                        clk_cnt <= clk_cnt + 1'b1;
                end
                rx_data:
                begin
                    if (clk_cnt == bit_last)
                    begin
                        clk_cnt <= '0;
                        if (bit_cnt == data_last)
                            state <= rx_stop;
                        else
                            bit_cnt <= bit_cnt + 1'b1;
                    end
                    else
                        clk_cnt <= clk_cnt + 1'b1;
                end
                rx_stop:
                begin
                    if (clk_cnt == bit_last)
                    begin
                        done  <= rx_sync;   // low stop bit, frame discarded
                        state <= rx_idle;
                    end
                    else
                        clk_cnt <= clk_cnt + 1'b1;
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // shift holds the byte until the next frame's data bits
    assign rx_evt.done = done;
    assign rx_evt.data = shift;

endmodule

// ==== verilog/uart_regs.sv ====
`timescale 1ns/10ps
/*
 * serial port register block
 * decodes the four-word window, holds tx data, irq enable, rx data
 * and status flags, answers reads one cycle later and forms the irq strobe
 */
module uart_regs #(
    parameter logic [15:0] base_addr = 16'hff08
) (
    input  logic                   clk,
    input  logic                   reset,
    input  uart_bus_pkg::bus_req_t bus_req,
    output uart_bus_pkg::bus_rsp_t bus_rsp,
    input  logic                   tx_busy,
    input  uart_line_pkg::rx_evt_t rx_evt,
    output uart_line_pkg::tx_cmd_t tx_cmd,
    output logic                   irq
);
    import uart_bus_pkg::*;
    import uart_line_pkg::*;

    logic [15:0]           offset_full;
    reg_offset_e           offset;
    logic                  hit;
    logic                  wr;
    logic                  rd;
    logic [frame_bits-1:0] tx_data_q;
    logic                  irq_en_q;
    logic [frame_bits-1:0] rx_data_q;
    logic                  rx_valid_q;
    logic                  rx_overrun_q;
    logic                  rsp_valid_q;
    logic [15:0]           rsp_data_q;
    logic [15:0]           status;
    logic [15:0]           rd_data;

    // window of four words from base_addr
    assign offset_full = bus_req.addr - base_addr;
    assign offset      = reg_offset_e'(offset_full[1:0]);
    assign hit         = bus_req.sel && (offset_full[15:2] == '0);
    assign wr          = hit && bus_req.write;
    assign rd          = hit && !bus_req.write;

    // start strobe in the write cycle, busy shows one cycle later
    assign tx_cmd.start = wr && (offset == reg_ctrl) && bus_req.wdata[0];
    assign tx_cmd.data  = tx_data_q;

    always_comb
    begin
        status                  = '0;
        status[stat_tx_busy]    = tx_busy;
        status[stat_rx_valid]   = rx_valid_q;
        status[stat_rx_overrun] = rx_overrun_q;
    end

    always_comb
    begin
        case (offset)
            reg_ctrl:    rd_data = status;
            reg_tx_data: rd_data = {{(16 - frame_bits){1'b0}}, tx_data_q};
            reg_irq_en:  rd_data = {15'b0, irq_en_q};
            reg_rx_data: rd_data = {{(16 - frame_bits){1'b0}}, rx_data_q};
            default:     rd_data = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            tx_data_q <= '0;
            irq_en_q  <= 1'b0;
        end
        else if (wr)
        begin
            if (offset == reg_tx_data)
                tx_data_q <= bus_req.wdata[frame_bits-1:0];
            if (offset == reg_irq_en)
                irq_en_q <= bus_req.wdata[0];
        end
    end

    // receive side, a new byte wins over a same-cycle read clear
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            rx_data_q    <= '0;
            rx_valid_q   <= 1'b0;
            rx_overrun_q <= 1'b0;
            irq          <= 1'b0;
        end
        else
        begin
            irq <= rx_evt.done && irq_en_q;     // lines up with rx_valid rising
            if (rx_evt.done)
            begin
                rx_data_q  <= rx_evt.data;
                rx_valid_q <= 1'b1;
            end
            else if (rd && offset == reg_rx_data)
                rx_valid_q <= 1'b0;

            if (rx_evt.done && rx_valid_q && !(rd && offset == reg_rx_data))
                rx_overrun_q <= 1'b1;           // unread byte replaced
            else if (rd && offset == reg_ctrl)
                rx_overrun_q <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
            rsp_valid_q <= 1'b0;
        else
            rsp_valid_q <= rd;
    end

    always_ff @(posedge clk)
    begin
        if (rd)
            rsp_data_q <= rd_data;
    end

    assign bus_rsp.valid = rsp_valid_q;
    assign bus_rsp.rdata = rsp_data_q;

endmodule

// ==== verilog/uart_periph.sv ====
`timescale 1ns/10ps
/*
 * memory-mapped serial port
 * register block on the 16-bit bus, bit tick generator,
 * 8N1 transmitter and mid-bit sampling receiver
 */
module uart_periph #(
    parameter int          clks_per_bit = 16,
    parameter logic [15:0] base_addr    = 16'hff08
) (
    input  logic                   clk,
    input  logic                   reset,
    input  uart_bus_pkg::bus_req_t bus_req,
    output uart_bus_pkg::bus_rsp_t bus_rsp,
    input  logic                   rx,
    output logic                   tx,
    output logic                   irq
);
    import uart_line_pkg::*;

    logic    tick;
    logic    tx_busy;
    tx_cmd_t tx_cmd;
    rx_evt_t rx_evt;

    baud_tick_gen #(
        .clks_per_bit (clks_per_bit)
    ) u_tick (
        .clk   (clk),
        .reset (reset),
        .tick  (tick)
    );

    uart_regs #(
        .base_addr (base_addr)
    ) u_regs (
        .clk     (clk),
        .reset   (reset),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .tx_busy (tx_busy),
        .rx_evt  (rx_evt),
        .tx_cmd  (tx_cmd),
        .irq     (irq)
    );

    uart_tx u_tx (
        .clk     (clk),
        .reset   (reset),
        .tick    (tick),
        .tx_cmd  (tx_cmd),
        .tx      (tx),
        .tx_busy (tx_busy)
    );

    // receiver keeps its own bit timing
    uart_rx #(
        .clks_per_bit (clks_per_bit)
    ) u_rx (
        .clk    (clk),
        .reset  (reset),
        .rx     (rx),
        .rx_evt (rx_evt)
    );

endmodule

// ==== dv/uart_props.sv ====
`timescale 1ns/10ps
/*
 * concurrent assertions bound into the serial port top level
 * tx idle level, read response timing and irq pulse width
 */
module uart_props #(
    parameter logic [15:0] base_addr = 16'hff08
) (
    input logic                   clk,
    input logic                   reset,
    input uart_bus_pkg::bus_req_t bus_req,
    input uart_bus_pkg::bus_rsp_t bus_rsp,
    input logic                   tx,
    input logic                   tx_busy,
    input logic                   irq
);

    logic [15:0] offset;
    logic        rd_hit;

    assign offset = bus_req.addr - base_addr;
    assign rd_hit = bus_req.sel && !bus_req.write && (offset[15:2] == 14'd0);

    // line rests high whenever no frame is pending or on the wire
    tx_idle_high: assert property (@(posedge clk) disable iff (!reset) !tx_busy |-> tx)
        else $error("tx low while the transmitter is idle");

    rsp_follows_read: assert property (@(posedge clk) disable iff (!reset)
        rd_hit |=> bus_rsp.valid)
        else $error("read hit without a response one cycle later");

    rsp_only_after_read: assert property (@(posedge clk) disable iff (!reset)
        bus_rsp.valid |-> $past(rd_hit))
        else $error("read response without a read hit the cycle before");

    irq_single_cycle: assert property (@(posedge clk) disable iff (!reset) irq |=> !irq)
        else $error("irq high for two cycles");

endmodule

// ==== dv/uart_tb.sv ====
`timescale 1ns/10ps
/*
 * testbench for the memory-mapped serial port
 * runs bus, rx and irq operations from a vector file, decodes frames
 * seen on tx and compares everything with the expected values in the file
 */
module uart_tb;
    import uart_bus_pkg::*;

    localparam int          cpb         = 8;        // clocks per bit on both lines
    localparam logic [15:0] base_addr   = 16'hff08;
    localparam int          rsp_limit   = 8;
    localparam int          frame_limit = 300;      // cycles for one frame plus start latency

    logic     clk;
    logic     reset;
    bus_req_t bus_req;
    bus_rsp_t bus_rsp;
    logic     rx;
    logic     tx;
    logic     irq;

    logic [9:0] tx_frames[$];   // stop, data lsb first, start
    int         irq_seen = 0;
    int         irq_taken = 0;

    uart_periph #(
        .clks_per_bit (cpb)
    ) dut (
        .clk     (clk),
        .reset   (reset),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .rx      (rx),
        .tx      (tx),
        .irq     (irq)
    );

    bind uart_periph uart_props #(
        .base_addr (base_addr)
    ) u_props (
        .clk     (clk),
        .reset   (reset),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .tx      (tx),
        .tx_busy (tx_busy),
        .irq     (irq)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // irq cycles counted here and claimed by the I and N operations
    always @(negedge clk)
    begin
        if (reset === 1'b1 && irq === 1'b1)
            irq_seen <= irq_seen + 1;
    end

    // tx line model sampling each bit in its middle
    initial
    begin : tx_watch
        logic [9:0] frame;
        @(posedge reset);
        forever
        begin
            @(negedge clk);
            if (tx === 1'b0)
            begin
                repeat (cpb / 2 - 1) @(negedge clk);
                frame[0] = tx;
                for (int i = 1; i < 10; i++)
                begin
                    repeat (cpb) @(negedge clk);
                    frame[i] = tx;
                end
                repeat (cpb / 2 + 1) @(negedge clk);   // past the end of the stop bit
                tx_frames.push_back(frame);
            end
        end
    end

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (actual !== expected)
        begin
            $display("FAIL time %0t %s expected %h actual %h", $time, name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string why);
        $display("error at time %0t: %s", $time, why);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic idle_gap();
        int gap;
        gap = $urandom % 21;
        repeat (gap) @(posedge clk);
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [15:0] data);
        @(posedge clk);
        bus_req <= '{sel: 1'b1, write: 1'b1, addr: addr, wdata: data};
        @(posedge clk);
        bus_req.sel <= 1'b0;
    endtask

    // outside the window no response may come at all
    task automatic read_reg(input logic [15:0] addr, input logic [15:0] expected);
        int   wait_cnt;
        logic hit;
        hit = (addr - base_addr) < 16'd4;
        @(posedge clk);
        bus_req <= '{sel: 1'b1, write: 1'b0, addr: addr, wdata: 16'h0};
        @(posedge clk);
        bus_req.sel <= 1'b0;
        @(negedge clk);
        wait_cnt = 0;
        while (bus_rsp.valid !== 1'b1 && wait_cnt < rsp_limit)
        begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!hit)
            check_value("bus_rsp.valid", 16'd0, {15'd0, bus_rsp.valid});
        else if (bus_rsp.valid !== 1'b1)
            abort_run("no read response arrived in time");
        else
        begin
            check_value("bus_rsp latency", 16'd0, 16'(wait_cnt));
            check_value("bus_rsp.rdata", expected, bus_rsp.rdata);
        end
    endtask

    task automatic send_byte(input logic [7:0] data);
        logic [9:0] bits;
        bits = {1'b1, data, 1'b0};  // stop, data, start
        for (int i = 0; i < 10; i++)
        begin
            @(posedge clk);
            rx <= bits[i];
            repeat (cpb - 1) @(posedge clk);
        end
    endtask

    task automatic match_frame(input logic [7:0] data);
        int         wait_cnt;
        logic [9:0] frame;
        wait_cnt = 0;
        while (tx_frames.size() == 0 && wait_cnt < frame_limit)
        begin
            @(negedge clk);
            wait_cnt++;
        end
        if (tx_frames.size() == 0)
            abort_run("no frame appeared on tx in time");
        else
        begin
            frame = tx_frames.pop_front();
            check_value("tx frame", {6'd0, 1'b1, data, 1'b0}, {6'd0, frame});
        end
    endtask

    task automatic wait_irq();
        int wait_cnt;
        wait_cnt = 0;
        while (irq_seen == irq_taken && wait_cnt < frame_limit)
        begin
            @(negedge clk);
            wait_cnt++;
        end
        if (irq_seen == irq_taken)
            abort_run("no irq pulse arrived in time");
        else
        begin
            repeat (2) @(negedge clk);  // a second cycle would count twice
            check_value("irq pulse count", 16'd1, 16'(irq_seen - irq_taken));
            irq_taken = irq_seen;
        end
    endtask

    task automatic no_irq_window();
        repeat (12 * cpb) @(negedge clk);
        check_value("irq pulse count", 16'd0, 16'(irq_seen - irq_taken));
    endtask

    initial
    begin : run_vectors
        int          fd;
        int          c;
        int          n;
        logic [7:0]  op;
        logic [15:0] a;
        logic [15:0] b;

        void'($urandom(32'hd071));
        reset   <= 1'b0;
        bus_req <= '0;
        rx      <= 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b1;

        fd = $fopen("dv/uart_vectors.txt", "r");
        if (fd == 0)
            abort_run("cannot open dv/uart_vectors.txt");
        c = $fgetc(fd);
        while (c != -1)
        begin
            op = c[7:0];
            case (op)
                "#":
                begin
                    while (c != 10 && c != -1)
                        c = $fgetc(fd);
                end
                "W", "R":
                begin
                    n = $fscanf(fd, "%h %h", a, b);
                    if (n != 2)
                        abort_run("bus operation without address and data");
                    else if (op == "W")
                        write_reg(a, b);
                    else
                        read_reg(a, b);
                end
                "S", "T":
                begin
                    n = $fscanf(fd, "%h", a);
                    if (n != 1)
                        abort_run("serial operation without a byte");
                    else if (op == "S")
                        send_byte(a[7:0]);
                    else
                        match_frame(a[7:0]);
                end
                "I": wait_irq();
                "N": no_irq_window();
                8'h20, 8'h09, 8'h0a, 8'h0d: ;     // blanks between fields
                default: abort_run("unknown operation in the vector file");
            endcase
            if (op inside {"W", "R", "S", "T", "I", "N"})
                idle_gap();
            c = $fgetc(fd);
        end
        $fclose(fd);

        // nothing left over once the line settles
        repeat (20 * cpb) @(negedge clk);
        check_value("unclaimed tx frames", 16'd0, 16'(tx_frames.size()));
        check_value("unclaimed irq pulses", 16'd0, 16'(irq_seen - irq_taken));
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== dv/uart_vectors.txt ====
# op addr data | op addr expected (no response outside ff08..ff0b)
# S byte into rx, T byte expected on tx, I one irq pulse, N no irq pulse
R ff08 0000
R ff0b 0000
W ff09 0055
R ff09 0055
W ff0a 0001
R ff0a 0001
W ff0a 0000
W ff0c 00ff
W ff07 00ff
R ff09 0055
R ff0a 0000
R ff0c 0000
R ff07 0000
# transmit, busy during the frame
W ff09 00a5
W ff08 0001
R ff08 0001
T a5
R ff08 0000
# receive
S 5c
R ff08 0002
R ff0b 005c
R ff08 0000
# interrupt on and off
W ff0a 0001
S 3c
I
R ff0b 003c
W ff0a 0000
S 81
N
R ff0b 0081
# overrun, second byte wins
S 11
S e7
R ff08 0006
R ff08 0002
R ff0b 00e7
R ff08 0000
# start while busy gives one frame
W ff09 005a
W ff08 0001
W ff08 0001
T 5a
R ff08 0000

// ==== flist.f ====
verilog/uart_bus_pkg.sv
verilog/uart_line_pkg.sv
verilog/baud_tick_gen.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_regs.sv
verilog/uart_periph.sv
dv/uart_props.sv
dv/uart_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the serial port testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module uart_tb -f flist.f -o uart_sim

out=$(./obj_dir/uart_sim || true)
echo "$out"
if echo "$out" | grep -qF "RESULT: PASS"; then
    exit 0
else
    exit 1
fi
